// ==== design/autotest_sequencer.sv ====
/*
  Self-test sequencer
  Initialises the SD host, reads a vector block, starts the UUT run,
  compares the result, writes the result block back and steps to the
  next block. Halts on the first block with a bad signature.
*/
`timescale 1ns/100ps

module autotest_sequencer (
  input  logic                        clk,
  input  logic                        rst,
  input  sd_link_pkg::sd_rsp_t        sd_rsp_i,
  output sd_link_pkg::sd_req_t        sd_req_o,
  output logic                        cap_strobe_o,
  output logic [9:0]                  byte_ofs_o,
  input  logic                        sig_match_i,
  input  logic [31:0]                 expected_i,
  output logic                        run_start_o,
  input  logic                        run_done_i,
  input  logic [31:0]                 result_i,
  input  logic [31:0]                 exec_cycles_i,
  input  test_vector_pkg::debug_sel_e debug_sel_i,
  output logic [31:0]                 debug_o
);

  test_vector_pkg::seq_state_e state, next_state;

  logic [9:0]  byte_cnt;
  logic [31:0] block_addr;
  logic [31:0] err_cnt;
  logic [31:0] run_cnt;
  logic        byte_clr;
  logic        byte_inc;
  logic        addr_inc;
  logic        err_inc;
  logic        last_byte;
  logic [1:0]  wr_lane;
  logic [7:0]  wr_data;

  assign last_byte  = (byte_cnt == 10'(sd_link_pkg::BLOCK_BYTES - 1));
  assign byte_ofs_o = byte_cnt;

  // outgoing byte by offset in the result block
  always_comb begin
    wr_lane = byte_cnt[1:0];
    if (test_vector_pkg::in_field(byte_cnt, test_vector_pkg::OFS_RESULT)) begin
      wr_data = result_i[8*wr_lane +: 8];
    end else if (test_vector_pkg::in_field(byte_cnt, test_vector_pkg::OFS_EXEC)) begin
      wr_data = exec_cycles_i[8*wr_lane +: 8];
    end else begin
      wr_data = test_vector_pkg::PAD_BYTE;
    end
  end

  always_comb begin
    next_state          = state;
    sd_req_o            = '0;
    sd_req_o.block_addr = block_addr;
    sd_req_o.wdata      = wr_data;
    cap_strobe_o        = 1'b0;
    run_start_o         = 1'b0;
    byte_clr            = 1'b0;
    byte_inc            = 1'b0;
    addr_inc            = 1'b0;
    err_inc             = 1'b0;
    case (state)
      test_vector_pkg::ST_INIT: begin
        if (!sd_rsp_i.busy) begin
          sd_req_o.init = 1'b1;
          next_state    = test_vector_pkg::ST_INIT_WAIT;
        end
      end
      test_vector_pkg::ST_INIT_WAIT: begin
        if (!sd_rsp_i.busy) next_state = test_vector_pkg::ST_RD_BLOCK;
      end
      test_vector_pkg::ST_RD_BLOCK: begin
        if (!sd_rsp_i.busy) begin
          sd_req_o.rd_block = 1'b1;
          byte_clr          = 1'b1;
          next_state        = test_vector_pkg::ST_RD_BLOCK_WAIT;
        end
      end
      test_vector_pkg::ST_RD_BLOCK_WAIT: begin
        if (!sd_rsp_i.busy) next_state = test_vector_pkg::ST_RD_BYTE;
      end
      test_vector_pkg::ST_RD_BYTE: begin
        if (!sd_rsp_i.busy) begin
          sd_req_o.rd_byte = 1'b1;
          next_state       = test_vector_pkg::ST_RD_BYTE_WAIT;
        end
      end
      test_vector_pkg::ST_RD_BYTE_WAIT: begin
        // rdata valid as busy drops
        if (!sd_rsp_i.busy) begin
          cap_strobe_o = 1'b1;
          byte_clr     = last_byte;
          byte_inc     = !last_byte;
          next_state   = last_byte ? test_vector_pkg::ST_CHECK_SIG
                                   : test_vector_pkg::ST_RD_BYTE;
        end
      end
      test_vector_pkg::ST_CHECK_SIG: begin
        next_state = sig_match_i ? test_vector_pkg::ST_START : test_vector_pkg::ST_HALT;
      end
      test_vector_pkg::ST_START: begin
        run_start_o = 1'b1;
        next_state  = test_vector_pkg::ST_RUN;
      end
      test_vector_pkg::ST_RUN: begin
        if (run_done_i) next_state = test_vector_pkg::ST_COMPARE;
      end
      test_vector_pkg::ST_COMPARE: begin
        err_inc    = (result_i != expected_i);
        next_state = test_vector_pkg::ST_WR_BLOCK;
      end
      test_vector_pkg::ST_WR_BLOCK: begin
        if (!sd_rsp_i.busy) begin
          sd_req_o.wr_block = 1'b1;
          next_state        = test_vector_pkg::ST_WR_BLOCK_WAIT;
        end
      end
      test_vector_pkg::ST_WR_BLOCK_WAIT: begin
        if (!sd_rsp_i.busy) next_state = test_vector_pkg::ST_WR_BYTE;
      end
      test_vector_pkg::ST_WR_BYTE: begin
        if (!sd_rsp_i.busy) begin
          sd_req_o.wr_byte = 1'b1;
          next_state       = test_vector_pkg::ST_WR_BYTE_WAIT;
        end
      end
      test_vector_pkg::ST_WR_BYTE_WAIT: begin
        if (!sd_rsp_i.busy) begin
          byte_clr   = last_byte;
          byte_inc   = !last_byte;
          next_state = last_byte ? test_vector_pkg::ST_NEXT_BLOCK
                                 : test_vector_pkg::ST_WR_BYTE;
        end
      end
      test_vector_pkg::ST_NEXT_BLOCK: begin
        addr_inc   = 1'b1;
        next_state = test_vector_pkg::ST_RD_BLOCK;
      end
      default: begin
        // halted, nothing more goes to the card
        next_state = test_vector_pkg::ST_HALT;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= test_vector_pkg::ST_INIT;
      byte_cnt   <= '0;
      block_addr <= sd_link_pkg::START_BLOCK;
      err_cnt    <= '0;
      run_cnt    <= '0;
    end else begin
      state <= next_state;
      if (byte_clr) byte_cnt <= '0;
      else if (byte_inc) byte_cnt <= byte_cnt + 10'd1;
      if (addr_inc) block_addr <= block_addr + 32'd1;
      if (err_inc) err_cnt <= err_cnt + 32'd1;
      // total run time freezes on halt
      if (state != test_vector_pkg::ST_HALT) run_cnt <= run_cnt + 32'd1;
    end
  end

  always_comb begin
    case (debug_sel_i)
      test_vector_pkg::DBG_STATUS:  debug_o = {block_addr[15:0], 11'd0, state};
      test_vector_pkg::DBG_RUNTIME: debug_o = run_cnt;
      test_vector_pkg::DBG_ERRORS:  debug_o = err_cnt;
      default:                      debug_o = exec_cycles_i;
    endcase
  end

endmodule

// ==== design/autotest_top.sv ====
/*
  SD-card driven self-test, top level
  Connects the sequencer to the vector registers and to the UUT run
  timer. The SD host and the UUT sit outside this block.
*/
`timescale 1ns/100ps

module autotest_top (
  input  logic                          clk,
  input  logic                          rst,
  input  sd_link_pkg::sd_rsp_t          sd_rsp_i,
  output sd_link_pkg::sd_req_t          sd_req_o,
  input  logic                          uut_end_i,
  input  logic [31:0]                   uut_result_i,
  output logic                          uut_rst_o,
  output test_vector_pkg::operand_set_t uut_operands_o,
  input  test_vector_pkg::debug_sel_e   debug_sel_i,
  output logic [31:0]                   debug_o
);

  logic        cap_strobe;
  logic [9:0]  byte_ofs;
  logic        sig_match;
  logic [31:0] expected;
  logic        run_start;
  logic        run_done;
  logic [31:0] result;
  logic [31:0] exec_cycles;

  autotest_sequencer u_seq (
    .clk           (clk),
    .rst           (rst),
    .sd_rsp_i      (sd_rsp_i),
    .sd_req_o      (sd_req_o),
    .cap_strobe_o  (cap_strobe),
    .byte_ofs_o    (byte_ofs),
    .sig_match_i   (sig_match),
    .expected_i    (expected),
    .run_start_o   (run_start),
    .run_done_i    (run_done),
    .result_i      (result),
    .exec_cycles_i (exec_cycles),
    .debug_sel_i   (debug_sel_i),
    .debug_o       (debug_o)
  );

  // the block read request doubles as the vector clear
  vector_capture u_vec (
    .clk          (clk),
    .rst          (rst),
    .clear_i      (sd_req_o.rd_block),
    .cap_strobe_i (cap_strobe),
    .byte_ofs_i   (byte_ofs),
    .rdata_i      (sd_rsp_i.rdata),
    .sig_match_o  (sig_match),
    .operands_o   (uut_operands_o),
    .expected_o   (expected)
  );

  uut_run_timer u_timer (
    .clk           (clk),
    .rst           (rst),
    .start_i       (run_start),
    .uut_end_i     (uut_end_i),
    .uut_result_i  (uut_result_i),
    .uut_rst_o     (uut_rst_o),
    .done_o        (run_done),
    .result_o      (result),
    .exec_cycles_o (exec_cycles)
  );

endmodule

// ==== design/sd_link_pkg.sv ====
/*
  SD link definitions
  Request and response words exchanged with the SD host, plus the
  block size and the first block address that the self-test uses.
*/
package sd_link_pkg;

  // bytes in one SD block transfer
  localparam int BLOCK_BYTES = 512;

  // first test-vector block
  localparam logic [31:0] START_BLOCK = 32'h0010_0000;

  // one strobe at a time, each for one cycle, only while busy is low
  typedef struct packed {
    logic        init;
    logic        rd_block;
    logic        rd_byte;
    logic        wr_block;
    logic        wr_byte;
    logic [31:0] block_addr;
    logic [7:0]  wdata;
  } sd_req_t;

  // rdata valid in the first cycle busy is low after rd_byte
  typedef struct packed {
    logic       busy;
    logic [7:0] rdata;
  } sd_rsp_t;

endpackage

// ==== design/test_vector_pkg.sv ====
/*
  Test-vector definitions
  Block layout, signature and timeout of the self-test, the operand
  set handed to the UUT, the sequencer states and the debug selector.
*/
package test_vector_pkg;

  localparam int OPERAND_W     = 32;
  localparam int OPERAND_BYTES = 4;

  // stored most significant byte first
  localparam logic [31:0] SIGNATURE = 32'hAABB_CCDD;

  // operands and expected value of the read block go LSB first
  localparam logic [9:0] OFS_SIG = 10'd0;
  localparam logic [9:0] OFS_A   = 10'd4;
  localparam logic [9:0] OFS_B   = 10'd8;
  localparam logic [9:0] OFS_C   = 10'd12;
  localparam logic [9:0] OFS_EXP = 10'd16;

  // written block
  localparam logic [9:0] OFS_RESULT = 10'd0;
  localparam logic [9:0] OFS_EXEC   = 10'd4;

  localparam logic [31:0] TIMEOUT_CYCLES = 32'd2000;
  localparam logic [7:0]  PAD_BYTE       = 8'hFF;

  typedef struct packed {
    logic [OPERAND_W-1:0] a;
    logic [OPERAND_W-1:0] b;
    logic [OPERAND_W-1:0] c;
  } operand_set_t;

  typedef enum logic [4:0] {
    ST_INIT, ST_INIT_WAIT,
    ST_RD_BLOCK, ST_RD_BLOCK_WAIT, ST_RD_BYTE, ST_RD_BYTE_WAIT,
    ST_CHECK_SIG, ST_START, ST_RUN, ST_COMPARE,
    ST_WR_BLOCK, ST_WR_BLOCK_WAIT, ST_WR_BYTE, ST_WR_BYTE_WAIT,
    ST_NEXT_BLOCK, ST_HALT
  } seq_state_e;

  typedef enum logic [1:0] {
    DBG_STATUS, DBG_RUNTIME, DBG_ERRORS, DBG_EXEC
  } debug_sel_e;

  // true when a byte offset falls inside a 4-byte field
  function automatic logic in_field(input logic [9:0] ofs, input logic [9:0] base);
    return (ofs >= base) && (ofs < base + 10'(OPERAND_BYTES));
  endfunction

endpackage

// ==== design/uut_run_timer.sv ====
/*
  UUT run timer
  Keeps the UUT in reset between tests, releases it on start, counts
  execution cycles until the UUT ends or the timeout is reached, and
  registers the result and the cycle count.
*/
`timescale 1ns/100ps

module uut_run_timer (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 start_i,
  input  logic                                 uut_end_i,
  input  logic [test_vector_pkg::OPERAND_W-1:0] uut_result_i,
  output logic                                 uut_rst_o,
  output logic                                 done_o,
  output logic [31:0]                          result_o,
  output logic [31:0]                          exec_cycles_o
);

  logic        running;
  logic [31:0] cnt;
  logic [31:0] cnt_next;
  logic        finish;

  // count includes the current cycle
  assign cnt_next  = cnt + 32'd1;
  assign finish    = running && (uut_end_i || cnt_next == test_vector_pkg::TIMEOUT_CYCLES);
  assign uut_rst_o = !running;

  always_ff @(posedge clk) begin
    if (rst) begin
      running       <= 1'b0;
      done_o        <= 1'b0;
      exec_cycles_o <= '0;
    end else begin
      done_o <= finish;
      if (finish) begin
        running       <= 1'b0;
        exec_cycles_o <= cnt_next;
      end else if (start_i) begin
        running <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i && !running) cnt <= '0;
    else if (running) cnt <= cnt_next;
    // result sampled in the end cycle
    if (finish) result_o <= uut_result_i;
  end

endmodule

// ==== design/vector_capture.sv ====
/*
  Test-vector registers
  Picks the signature, the three operands and the expected result out
  of the bytes of a block read, and flags a matching signature.
*/
`timescale 1ns/100ps

module vector_capture (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          clear_i,
  input  logic                          cap_strobe_i,
  input  logic [9:0]                    byte_ofs_i,
  input  logic [7:0]                    rdata_i,
  output logic                          sig_match_o,
  output test_vector_pkg::operand_set_t operands_o,
  output logic [31:0]                   expected_o
);

  logic [31:0] sig_q;
  logic [1:0]  lane;

  // fields start on 4-byte boundaries
  assign lane = byte_ofs_i[1:0];

  always_ff @(posedge clk) begin
    if (rst || clear_i) begin
      sig_q <= '0;
    end else if (cap_strobe_i &&
                 test_vector_pkg::in_field(byte_ofs_i, test_vector_pkg::OFS_SIG)) begin
      // msb first
      sig_q[8*(2'd3 - lane) +: 8] <= rdata_i;
    end
  end

  always_ff @(posedge clk) begin
    if (cap_strobe_i) begin
      if (test_vector_pkg::in_field(byte_ofs_i, test_vector_pkg::OFS_A)) begin
        operands_o.a[8*lane +: 8] <= rdata_i;
      end
      if (test_vector_pkg::in_field(byte_ofs_i, test_vector_pkg::OFS_B)) begin
        operands_o.b[8*lane +: 8] <= rdata_i;
      end
      if (test_vector_pkg::in_field(byte_ofs_i, test_vector_pkg::OFS_C)) begin
        operands_o.c[8*lane +: 8] <= rdata_i;
      end
      if (test_vector_pkg::in_field(byte_ofs_i, test_vector_pkg::OFS_EXP)) begin
        expected_o[8*lane +: 8] <= rdata_i;
      end
    end
  end

  assign sig_match_o = (sig_q == test_vector_pkg::SIGNATURE);

endmodule

// ==== sd_autotest.f ====
design/sd_link_pkg.sv
design/test_vector_pkg.sv
design/vector_capture.sv
design/uut_run_timer.sv
design/autotest_sequencer.sv
design/autotest_top.sv
verification/sd_host_model.sv
verification/autotest_checker.sv
verification/tb_autotest.sv

// ==== verification/autotest_checker.sv ====
/*
  Self-test protocol assertions
  Bound into the top level. Watches the SD request strobes against
  busy and the UUT reset while the card is addressed.
*/
`timescale 1ns/100ps

module autotest_checker (
  input logic                 clk,
  input logic                 rst,
  input sd_link_pkg::sd_req_t req_i,
  input sd_link_pkg::sd_rsp_t rsp_i,
  input logic                 uut_rst_i
);

  logic [4:0]  strobes;
  int unsigned fail_count = 0;

  assign strobes = {req_i.init, req_i.rd_block, req_i.rd_byte, req_i.wr_block, req_i.wr_byte};

  a_one_strobe: assert property (@(posedge clk) disable iff (rst) $onehot0(strobes))
    else begin
      $error("more than one SD strobe active");
      fail_count++;
    end

  a_idle_host: assert property (@(posedge clk) disable iff (rst) |strobes |-> !rsp_i.busy)
    else begin
      $error("SD strobe raised while busy");
      fail_count++;
    end

  // card traffic only between tests
  a_uut_held: assert property (@(posedge clk) disable iff (rst) |strobes |-> uut_rst_i)
    else begin
      $error("SD strobe raised while the UUT runs");
      fail_count++;
    end

endmodule

bind autotest_top autotest_checker u_chk (
  .clk       (clk),
  .rst       (rst),
  .req_i     (sd_req_o),
  .rsp_i     (sd_rsp_i),
  .uut_rst_i (uut_rst_o)
);

// ==== verification/sd_host_model.sv ====
/*
  Behavioural SD host
  Holds a 512-byte store per block address, answers each request with
  a fixed busy phase and keeps counters of requests and whole blocks.
*/
`timescale 1ns/100ps

module sd_host_model #(
  parameter int NUM_BLOCKS  = 8,
  parameter int BUSY_CYCLES = 3
) (
  input  logic                 clk,
  input  logic                 rst,
  input  sd_link_pkg::sd_req_t req_i,
  output sd_link_pkg::sd_rsp_t rsp_o
);

  localparam int STORE_BYTES = NUM_BLOCKS * sd_link_pkg::BLOCK_BYTES;

  // blocks never written read back as zero
  bit [7:0]    store [STORE_BYTES];
  logic [31:0] cur_block;
  int unsigned ptr;
  int unsigned busy_left;
  int unsigned req_count;
  int unsigned blocks_read;
  int unsigned blocks_written;

  function automatic int unsigned index_of(input logic [31:0] block, input int unsigned ofs);
    return (block - sd_link_pkg::START_BLOCK) * sd_link_pkg::BLOCK_BYTES + ofs;
  endfunction

  task automatic put_byte(input logic [31:0] block, input int unsigned ofs,
                          input logic [7:0] data);
    int unsigned idx;
    idx = index_of(block, ofs);
    if (idx < STORE_BYTES) store[idx] = data;
  endtask

  function automatic logic [7:0] get_byte(input logic [31:0] block, input int unsigned ofs);
    int unsigned idx;
    idx = index_of(block, ofs);
    return (idx < STORE_BYTES) ? store[idx] : 8'h00;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      rsp_o          <= '0;
      busy_left      <= 0;
      ptr            <= 0;
      req_count      <= 0;
      blocks_read    <= 0;
      blocks_written <= 0;
    end else begin
      if (req_i.init || req_i.rd_block || req_i.rd_byte || req_i.wr_block || req_i.wr_byte) begin
        req_count  <= req_count + 1;
        rsp_o.busy <= 1'b1;
        busy_left  <= BUSY_CYCLES - 1;
      end else if (busy_left != 0) begin
        busy_left <= busy_left - 1;
      end else begin
        rsp_o.busy <= 1'b0;
      end
      if (req_i.rd_block || req_i.wr_block) begin
        cur_block <= req_i.block_addr;
        ptr       <= 0;
      end
      if (req_i.rd_byte) begin
        rsp_o.rdata <= get_byte(cur_block, ptr);
        ptr         <= ptr + 1;
        if (ptr == sd_link_pkg::BLOCK_BYTES - 1) blocks_read <= blocks_read + 1;
      end
      if (req_i.wr_byte) begin
        put_byte(cur_block, ptr, req_i.wdata);
        ptr <= ptr + 1;
        if (ptr == sd_link_pkg::BLOCK_BYTES - 1) blocks_written <= blocks_written + 1;
      end
    end
  end

endmodule

// ==== verification/tb_autotest.sv ====
/*
  Self-test testbench
  Runs the sequencer against the SD host model and an adder UUT model,
  then checks the written result blocks, the error count, execution
  times, the timeout and the halt on a bad signature.
*/
`timescale 1ns/100ps

module tb_autotest;

  localparam int CLK_PERIOD  = 4;
  localparam int HOST_BUSY   = 3;
  // strobe, busy phase, then the cycle busy is low
  localparam int BYTE_CYCLES = HOST_BUSY + 2;
  localparam int NUM_BLOCKS  = 5;
  localparam int WATCH_CYCLES = NUM_BLOCKS * (2 * sd_link_pkg::BLOCK_BYTES * BYTE_CYCLES
                                + int'(test_vector_pkg::TIMEOUT_CYCLES)) + 5000;

  logic                          clk;
  logic                          rst;
  sd_link_pkg::sd_req_t          sd_req;
  sd_link_pkg::sd_rsp_t          sd_rsp;
  logic                          uut_rst;
  logic                          uut_end;
  logic [31:0]                   uut_result;
  test_vector_pkg::operand_set_t uut_ops;
  test_vector_pkg::debug_sel_e   debug_sel;
  logic [31:0]                   debug;

  integer      seed;
  int unsigned run_cycles;
  int unsigned low_cycles;
  logic        end_seen;
  int unsigned measured_exec;
  logic [31:0] expected_errors;
  logic [31:0] vec_a [NUM_BLOCKS];
  logic [31:0] vec_b [NUM_BLOCKS];
  logic [31:0] vec_c [NUM_BLOCKS];
  logic [31:0] vec_exp [NUM_BLOCKS];

  autotest_top dut0 (
    .clk            (clk),
    .rst            (rst),
    .sd_rsp_i       (sd_rsp),
    .sd_req_o       (sd_req),
    .uut_end_i      (uut_end),
    .uut_result_i   (uut_result),
    .uut_rst_o      (uut_rst),
    .uut_operands_o (uut_ops),
    .debug_sel_i    (debug_sel),
    .debug_o        (debug)
  );

  sd_host_model #(.NUM_BLOCKS(NUM_BLOCKS), .BUSY_CYCLES(HOST_BUSY)) host0 (
    .clk   (clk),
    .rst   (rst),
    .req_i (sd_req),
    .rsp_o (sd_rsp)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // adder UUT model that ends after c[7:0] + 1 released cycles
  always @(negedge clk) begin
    if (uut_rst) begin
      run_cycles = 0;
      uut_end    = 1'b0;
    end else begin
      run_cycles = run_cycles + 1;
      uut_end    = !uut_ops.c[31] && (run_cycles == uut_ops.c[7:0] + 1);
    end
    uut_result = uut_end ? uut_ops.a + uut_ops.b + uut_ops.c : 32'd0;
    // low cycles of uut reset up to the first end
    if (rst || uut_rst) begin
      if (low_cycles != 0) measured_exec = low_cycles;
      low_cycles = 0;
      end_seen   = 1'b0;
    end else if (!end_seen) begin
      low_cycles = low_cycles + 1;
      end_seen   = uut_end;
    end
  end

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string test, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected 0x%08h actual 0x%08h", test, expected, actual);
      abort_run();
    end
  endtask

  task automatic load_vector(input int blk, input logic [31:0] sig);
    logic [31:0] addr;
    int unsigned key;
    int          ofs;
    addr = sd_link_pkg::START_BLOCK + blk;
    for (ofs = 0; ofs < sd_link_pkg::BLOCK_BYTES; ofs++) begin
      key = blk * sd_link_pkg::BLOCK_BYTES + ofs;
      host0.put_byte(addr, ofs, 8'(key ^ (key >> 8) ^ (key >> 3)));
    end
    // signature msb first, the rest lsb first
    for (ofs = 0; ofs < 4; ofs++) begin
      host0.put_byte(addr, ofs, sig[8*(3-ofs) +: 8]);
      host0.put_byte(addr, 4 + ofs, vec_a[blk][8*ofs +: 8]);
      host0.put_byte(addr, 8 + ofs, vec_b[blk][8*ofs +: 8]);
      host0.put_byte(addr, 12 + ofs, vec_c[blk][8*ofs +: 8]);
      host0.put_byte(addr, 16 + ofs, vec_exp[blk][8*ofs +: 8]);
    end
  endtask

  function automatic logic [31:0] written_word(input int blk, input int ofs);
    logic [31:0] w;
    for (int i = 0; i < 4; i++) begin
      w[8*i +: 8] = host0.get_byte(sd_link_pkg::START_BLOCK + blk, ofs + i);
    end
    return w;
  endfunction

  task automatic wait_block_written(input int blk);
    while (host0.blocks_written <= blk) @(negedge clk);
  endtask

  task automatic read_debug(input test_vector_pkg::debug_sel_e sel, output logic [31:0] value);
    @(negedge clk);
    debug_sel = sel;
    @(negedge clk);
    value = debug;
  endtask

  task automatic correct_vector_written(input int blk);
    logic [31:0] value;
    wait_block_written(blk);
    check_value("correct_vector result", vec_a[blk] + vec_b[blk] + vec_c[blk],
                written_word(blk, 0));
    for (int ofs = 8; ofs < sd_link_pkg::BLOCK_BYTES; ofs++) begin
      check_value("correct_vector pad", 32'h0000_00FF,
                  32'(host0.get_byte(sd_link_pkg::START_BLOCK + blk, ofs)));
    end
    read_debug(test_vector_pkg::DBG_ERRORS, value);
    check_value("correct_vector errors", expected_errors, value);
  endtask

  task automatic wrong_expected_counted(input int blk);
    logic [31:0] value;
    wait_block_written(blk);
    check_value("wrong_expected result", vec_a[blk] + vec_b[blk] + vec_c[blk],
                written_word(blk, 0));
    expected_errors = expected_errors + 1;
    read_debug(test_vector_pkg::DBG_ERRORS, value);
    check_value("wrong_expected errors", expected_errors, value);
  endtask

  task automatic exec_time_recorded(input int blk);
    logic [31:0] value;
    wait_block_written(blk);
    check_value("exec_time model", 32'(vec_c[blk][7:0]) + 1, measured_exec);
    check_value("exec_time written", measured_exec, written_word(blk, 4));
    read_debug(test_vector_pkg::DBG_EXEC, value);
    check_value("exec_time debug", measured_exec, value);
  endtask

  task automatic timeout_enforced(input int blk);
    logic [31:0] value;
    wait_block_written(blk);
    check_value("timeout cycles", test_vector_pkg::TIMEOUT_CYCLES, written_word(blk, 4));
    // the model never ended, so its output stayed zero
    check_value("timeout result", 32'd0, written_word(blk, 0));
    expected_errors = expected_errors + 1;
    read_debug(test_vector_pkg::DBG_ERRORS, value);
    check_value("timeout errors", expected_errors, value);
  endtask

  task automatic halt_on_bad_signature(input int blk);
    logic [31:0] runtime;
    logic [31:0] value;
    int unsigned requests;
    logic [31:0] addr;
    addr = sd_link_pkg::START_BLOCK + blk;
    while (host0.blocks_read <= blk) @(negedge clk);
    repeat (20) @(negedge clk);
    requests = host0.req_count;
    read_debug(test_vector_pkg::DBG_RUNTIME, runtime);
    repeat (200) @(negedge clk);
    check_value("bad_signature requests", requests, host0.req_count);
    check_value("bad_signature writes", blk, host0.blocks_written);
    read_debug(test_vector_pkg::DBG_RUNTIME, value);
    check_value("bad_signature runtime", runtime, value);
    read_debug(test_vector_pkg::DBG_STATUS, value);
    check_value("bad_signature status", {addr[15:0], 11'd0, test_vector_pkg::ST_HALT}, value);
  endtask

  always @(negedge clk) begin
    if (dut0.u_chk.fail_count != 0) begin
      $display("bound protocol assertion failed");
      abort_run();
    end
  end

  initial begin
    #(WATCH_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the tests completed");
    abort_run();
  end

  initial begin
    seed            = 80230;
    rst             = 1'b1;
    debug_sel       = test_vector_pkg::DBG_STATUS;
    uut_end         = 1'b0;
    uut_result      = 32'd0;
    expected_errors = 32'd0;
    for (int blk = 0; blk < NUM_BLOCKS; blk++) begin
      vec_a[blk] = $random(seed);
      vec_b[blk] = $random(seed);
    end
    vec_c[0] = 32'h0000_0005;
    vec_c[1] = 32'h0000_0102;
    vec_c[2] = 32'h0000_0040;
    // never ends
    vec_c[3] = 32'h8000_0007;
    vec_c[4] = 32'h0000_0001;
    for (int blk = 0; blk < NUM_BLOCKS; blk++) begin
      vec_exp[blk] = vec_a[blk] + vec_b[blk] + vec_c[blk];
    end
    vec_exp[1] = vec_exp[1] + 32'd1;
    for (int blk = 0; blk < NUM_BLOCKS - 1; blk++) begin
      load_vector(blk, 32'hAABB_CCDD);
    end
    load_vector(NUM_BLOCKS - 1, 32'hAABB_CCDC);
    repeat (3) @(negedge clk);
    rst = 1'b0;
    correct_vector_written(0);
    wrong_expected_counted(1);
    exec_time_recorded(2);
    timeout_enforced(3);
    halt_on_bad_signature(4);
    if (dut0.u_chk.fail_count == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("bound assertions failed %0d times", dut0.u_chk.fail_count);
      abort_run();
    end
  end

endmodule
